// File: Bender.yml
package:
  name: psr_unit

export_include_dirs:
  - include

sources:
  - logic/psrPkg.sv
  - logic/exceptionPriority.sv
  - logic/msrMerge.sv
  - logic/psrRegFile.sv
  - logic/psrUnit.sv
  - target: test
    files:
      - verification/psrUnitTb.sv

// File: include/psr_config.svh
`ifndef PSR_CONFIG_SVH
`define PSR_CONFIG_SVH

// Register geometry
`define PSR_WIDTH       32
`define PSR_SPSR_COUNT  5   // svc, abt, und, irq, fiq
`define PSR_SLOT_WIDTH  3
`define PSR_EXC_COUNT   6   // undef, swi, pabt, dabt, irq, fiq

// Condition flags N Z C V
`define PSR_FLAGS_MSB   31
`define PSR_FLAGS_LSB   28

// Control byte layout
`define PSR_CTRL_WIDTH  8
`define PSR_I_BIT       7   // IRQ mask
`define PSR_F_BIT       6   // FIQ mask
`define PSR_T_BIT       5   // Thumb, always cleared here
`define PSR_MODE_WIDTH  5
`define PSR_ENDIAN_BIT  9   // Big endian on reset and exception entry

// MSR byte fields c, x, s, f
`define PSR_FIELD_WIDTH 8
`define PSR_FIELD_COUNT 4
`define PSR_FLAGS_FIELD 3   // Writable from any mode

`define PSR_RESET_CTRL  8'hD3 // Supervisor, I and F set

`endif

// File: logic/exceptionPriority.sv
`timescale 1ns/1ps
`default_nettype none

`include "psr_config.svh"

module exceptionPriority (
  input  logic [`PSR_EXC_COUNT-1:0]  exceptions, // undef, swi, pabt, dabt, irq, fiq
  input  logic [`PSR_WIDTH-1:0]      cpsr,
  output logic                       excTake,
  output psrPkg::excCause            excCause,
  output psrPkg::spsrSlot            excSlot,
  output logic [`PSR_CTRL_WIDTH-1:0] excCtrl,
  output logic                       excUseNewFlags
);
  import psrPkg::*;

  logic undefReq, swiReq, prefetchReq, dataAbortReq, irqReq, fiqReq;
  cpuMode curMode;
  cpuMode targetMode;

  assign {undefReq, swiReq, prefetchReq, dataAbortReq, irqReq, fiqReq} = exceptions;
  assign curMode = cpuMode'(cpsr[`PSR_MODE_WIDTH-1:0]);

  // Fixed priority, skip requests aimed at the mode we are already in
  always_comb begin
    if (dataAbortReq && curMode != modeAbt) excCause = causeDataAbort;
    else if (fiqReq && curMode != modeFiq) excCause = causeFiq;
    else if (irqReq && curMode != modeIrq) excCause = causeIrq;
    else if (prefetchReq && curMode != modeAbt) excCause = causePrefetchAbort;
    else if (undefReq && curMode != modeUnd) excCause = causeUndefined;
    else if (swiReq && curMode != modeSvc) excCause = causeSwi;
    else excCause = causeNone;
  end

  assign excTake = (excCause != causeNone);

  // Target mode, bank and flag source per cause
  always_comb begin
    targetMode     = curMode;
    excSlot        = slotSvc;
    excUseNewFlags = 1'b0;
    case (excCause)
      causeDataAbort: begin
        targetMode     = modeAbt;
        excSlot        = slotAbt;
        excUseNewFlags = 1'b1; // Faulting instr flags still land
      end
      causeFiq: begin
        targetMode     = modeFiq;
        excSlot        = slotFiq;
        excUseNewFlags = 1'b1;
      end
      causeIrq: begin
        targetMode     = modeIrq;
        excSlot        = slotIrq;
        excUseNewFlags = 1'b1;
      end
      causePrefetchAbort: begin
        targetMode = modeAbt;
        excSlot    = slotAbt;
      end
      causeUndefined: begin
        targetMode = modeUnd;
        excSlot    = slotUnd;
      end
      causeSwi: begin
        targetMode = modeSvc;
        excSlot    = slotSvc;
      end
      default: ; // No entry, defaults hold
    endcase
  end

  // Entry control byte
  always_comb begin
    excCtrl = cpsr[`PSR_CTRL_WIDTH-1:0];
    if (excTake) begin
      excCtrl[`PSR_I_BIT] = 1'b1;                                       // IRQ always masked
      excCtrl[`PSR_F_BIT] = (excCause == causeFiq) ? 1'b1 : cpsr[`PSR_F_BIT];
      excCtrl[`PSR_T_BIT] = 1'b0;                                       // Back to ARM state
      excCtrl[`PSR_MODE_WIDTH-1:0] = targetMode;
    end
  end

endmodule

`default_nettype wire

// File: logic/msrMerge.sv
`timescale 1ns/1ps
`default_nettype none

`include "psr_config.svh"

module msrMerge (
  input  logic [`PSR_WIDTH-1:0] aluOut,
  input  logic [4:0]            msrMask,     // R, f, s, x, c
  input  logic [`PSR_WIDTH-1:0] cpsr,
  input  logic [`PSR_WIDTH-1:0] currentSpsr,
  output logic                  msrCpsrWe,
  output logic                  msrSpsrWe,
  output logic [`PSR_WIDTH-1:0] msrValue
);
  import psrPkg::*;

  cpuMode curMode;
  logic privileged;
  logic hasSpsr;
  logic legalMode;
  logic anyField;
  logic toSpsr;
  logic [`PSR_WIDTH-1:0] target;

  assign curMode    = cpuMode'(cpsr[`PSR_MODE_WIDTH-1:0]);
  assign privileged = (curMode != modeUsr);
  assign hasSpsr    = privileged && (curMode != modeSys); // usr and sys have no bank
  assign toSpsr     = msrMask[4];
  assign target     = toSpsr ? currentSpsr : cpsr;       // Unmasked bytes come from here

  // Only architectural mode codes may be written
  always_comb begin
    case (aluOut[`PSR_MODE_WIDTH-1:0])
      modeUsr, modeFiq, modeIrq, modeSvc, modeAbt, modeUnd, modeSys:
        legalMode = 1'b1;
      default:
        legalMode = 1'b0;
    endcase
  end

  // Byte-wise merge of c, x, s, f fields
  always_comb begin
    logic fieldOpen;
    msrValue = target;
    for (int b = 0; b < `PSR_FIELD_COUNT; b++) begin
      fieldOpen = msrMask[b] && (privileged || b == `PSR_FLAGS_FIELD);
      if (fieldOpen) begin
        msrValue[b*`PSR_FIELD_WIDTH +: `PSR_FIELD_WIDTH] =
          aluOut[b*`PSR_FIELD_WIDTH +: `PSR_FIELD_WIDTH];
      end
    end
    // Bad mode code keeps the old mode but the rest of the c byte still lands
    if (msrMask[0] && privileged && !legalMode) begin
      msrValue[`PSR_MODE_WIDTH-1:0] = target[`PSR_MODE_WIDTH-1:0];
    end
  end

  assign anyField  = |msrMask[3:0];
  assign msrCpsrWe = anyField && !toSpsr;
  assign msrSpsrWe = anyField && toSpsr && hasSpsr; // No bank to write in usr or sys

endmodule

`default_nettype wire

// File: logic/psrPkg.sv
`default_nettype none

`include "psr_config.svh"

package psrPkg;

  // Architectural mode codes, CPSR[4:0]
  typedef enum logic [`PSR_MODE_WIDTH-1:0] {
    modeUsr = 5'b10000,
    modeFiq = 5'b10001,
    modeIrq = 5'b10010,
    modeSvc = 5'b10011,
    modeAbt = 5'b10111,
    modeUnd = 5'b11011,
    modeSys = 5'b11111
  } cpuMode;

  // Winning exception of the cycle
  typedef enum logic [2:0] {
    causeNone,
    causeDataAbort,
    causeFiq,
    causeIrq,
    causePrefetchAbort,
    causeUndefined,
    causeSwi
  } excCause;

  // Index into the SPSR bank
  typedef enum logic [`PSR_SLOT_WIDTH-1:0] {
    slotSvc = 3'd0,
    slotAbt = 3'd1,
    slotUnd = 3'd2,
    slotIrq = 3'd3,
    slotFiq = 3'd4
  } spsrSlot;

endpackage

`default_nettype wire

// File: logic/psrRegFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "psr_config.svh"

module psrRegFile (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    notStall,
  input  logic                                    excTake,
  input  psrPkg::spsrSlot                         excSlot,
  input  logic [`PSR_CTRL_WIDTH-1:0]              excCtrl,
  input  logic                                    excUseNewFlags,
  input  logic [`PSR_FLAGS_MSB:`PSR_FLAGS_LSB]    flagsUpdate,
  input  logic                                    msrCpsrWe,
  input  logic                                    msrSpsrWe,
  input  logic [`PSR_WIDTH-1:0]                   msrValue,
  input  logic                                    restoreCpsr,
  input  logic                                    flagsWrite,
  output logic [`PSR_WIDTH-1:0]                   cpsr,
  output logic [`PSR_WIDTH-1:0]                   currentSpsr,
  output psrPkg::spsrSlot                         curSlot
);
  import psrPkg::*;

  logic [`PSR_WIDTH-1:0] spsrBank [`PSR_SPSR_COUNT];
  logic hasSpsr;
  logic [`PSR_FLAGS_MSB:`PSR_FLAGS_LSB] entryFlags;
  logic [`PSR_WIDTH-1:0] savedWord;
  logic [`PSR_WIDTH-1:0] entryCpsr;
  logic [`PSR_WIDTH-1:0] resetCpsr;

  // Bank of the current mode
  always_comb begin
    curSlot = slotSvc;
    hasSpsr = 1'b1;
    case (cpuMode'(cpsr[`PSR_MODE_WIDTH-1:0]))
      modeFiq: curSlot = slotFiq;
      modeIrq: curSlot = slotIrq;
      modeSvc: curSlot = slotSvc;
      modeAbt: curSlot = slotAbt;
      modeUnd: curSlot = slotUnd;
      default: hasSpsr = 1'b0; // usr, sys
    endcase
  end

  assign currentSpsr = hasSpsr ? spsrBank[curSlot] : cpsr; // usr/sys read back CPSR

  // Words written on exception entry
  assign entryFlags = excUseNewFlags ? flagsUpdate : cpsr[`PSR_FLAGS_MSB:`PSR_FLAGS_LSB];
  assign savedWord  = {entryFlags, cpsr[`PSR_FLAGS_LSB-1:0]};

  always_comb begin
    entryCpsr = '0;
    entryCpsr[`PSR_FLAGS_MSB:`PSR_FLAGS_LSB] = entryFlags;
    entryCpsr[`PSR_ENDIAN_BIT]               = 1'b1;
    entryCpsr[`PSR_CTRL_WIDTH-1:0]           = excCtrl;
  end

  always_comb begin
    resetCpsr = '0;
    resetCpsr[`PSR_ENDIAN_BIT]     = 1'b1;
    resetCpsr[`PSR_CTRL_WIDTH-1:0] = `PSR_RESET_CTRL;
  end

  // One update per cycle, highest priority first
  always_ff @(posedge clk) begin
    if (reset) begin
      cpsr <= resetCpsr;
      for (int i = 0; i < `PSR_SPSR_COUNT; i++) begin
        spsrBank[i] <= '0;
      end
    end else if (notStall) begin
      if (excTake) begin
        spsrBank[excSlot] <= savedWord; // Old CPSR into target bank
        cpsr              <= entryCpsr;
      end else if (msrCpsrWe) begin
        cpsr <= msrValue;
      end else if (msrSpsrWe) begin
        spsrBank[curSlot] <= msrValue;
      end else if (restoreCpsr) begin
        cpsr <= currentSpsr;
      end else if (flagsWrite) begin
        cpsr[`PSR_FLAGS_MSB:`PSR_FLAGS_LSB] <= flagsUpdate;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/psrUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "psr_config.svh"

module psrUnit (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [`PSR_FLAGS_MSB:`PSR_FLAGS_LSB] flagsNext,
  input  logic                                 flagsWrite,
  input  logic [`PSR_WIDTH-1:0]                aluOut,
  input  logic [4:0]                           msrMask,
  input  logic [`PSR_EXC_COUNT-1:0]            exceptions,
  input  logic                                 restoreCpsr,
  input  logic                                 notStall,
  input  logic                                 coprocFlagUpdate,
  output logic [`PSR_WIDTH-1:0]                cpsrData,
  output logic [`PSR_WIDTH-1:0]                spsrData
);
  import psrPkg::*;

  logic [`PSR_WIDTH-1:0] cpsr;
  logic [`PSR_WIDTH-1:0] currentSpsr;
  logic [`PSR_FLAGS_MSB:`PSR_FLAGS_LSB] flagsUpdate;
  logic excTake;
  spsrSlot excSlot;
  logic [`PSR_CTRL_WIDTH-1:0] excCtrl;
  logic excUseNewFlags;
  logic msrCpsrWe;
  logic msrSpsrWe;
  logic [`PSR_WIDTH-1:0] msrValue;

  // Coprocessor transfers deliver flags on the ALU bus
  assign flagsUpdate = coprocFlagUpdate ? aluOut[`PSR_FLAGS_MSB:`PSR_FLAGS_LSB] : flagsNext;

  exceptionPriority i_exc (
    .exceptions     (exceptions),
    .cpsr           (cpsr),
    .excTake        (excTake),
    .excCause       (),
    .excSlot        (excSlot),
    .excCtrl        (excCtrl),
    .excUseNewFlags (excUseNewFlags)
  );

  msrMerge i_msr (
    .aluOut      (aluOut),
    .msrMask     (msrMask),
    .cpsr        (cpsr),
    .currentSpsr (currentSpsr),
    .msrCpsrWe   (msrCpsrWe),
    .msrSpsrWe   (msrSpsrWe),
    .msrValue    (msrValue)
  );

  psrRegFile i_regs (
    .clk            (clk),
    .reset          (reset),
    .notStall       (notStall),
    .excTake        (excTake),
    .excSlot        (excSlot),
    .excCtrl        (excCtrl),
    .excUseNewFlags (excUseNewFlags),
    .flagsUpdate    (flagsUpdate),
    .msrCpsrWe      (msrCpsrWe),
    .msrSpsrWe      (msrSpsrWe),
    .msrValue       (msrValue),
    .restoreCpsr    (restoreCpsr),
    .flagsWrite     (flagsWrite),
    .cpsr           (cpsr),
    .currentSpsr    (currentSpsr),
    .curSlot        ()              // Bank index used inside the register file
  );

  assign cpsrData = cpsr;
  assign spsrData = currentSpsr;

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
logic/psrPkg.sv
logic/exceptionPriority.sv
logic/msrMerge.sv
logic/psrRegFile.sv
logic/psrUnit.sv
verification/psrUnitTb.sv

// File: verification/psrUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "psr_config.svh"

module psrUnitTb;

  logic clk;
  logic reset;
  logic [`PSR_FLAGS_MSB:`PSR_FLAGS_LSB] flagsNext;
  logic flagsWrite;
  logic [`PSR_WIDTH-1:0] aluOut;
  logic [4:0] msrMask;
  logic [`PSR_EXC_COUNT-1:0] exceptions;
  logic restoreCpsr;
  logic notStall;
  logic coprocFlagUpdate;
  logic [`PSR_WIDTH-1:0] cpsrData;
  logic [`PSR_WIDTH-1:0] spsrData;

  logic [49:0] stimQ [$];   // {flags, flagsWrite, alu, mask, exceptions, restore, coproc}
  logic [63:0] expectQ [$]; // {cpsr, spsr} after the cycle
  int errorCount;
  bit traceLoaded;

  psrUnit i_dut (
    .clk              (clk),
    .reset            (reset),
    .flagsNext        (flagsNext),
    .flagsWrite       (flagsWrite),
    .aluOut           (aluOut),
    .msrMask          (msrMask),
    .exceptions       (exceptions),
    .restoreCpsr      (restoreCpsr),
    .notStall         (notStall),
    .coprocFlagUpdate (coprocFlagUpdate),
    .cpsrData         (cpsrData),
    .spsrData         (spsrData)
  );

  always #2 clk = ~clk; // 4 ns period

  // Comment lines start with #
  task automatic loadTrace();
    int fd;
    int n;
    string line;
    logic [3:0] fn;
    logic fw;
    logic [31:0] alu;
    logic [4:0] mask;
    logic [5:0] exc;
    logic rst;
    logic cop;
    logic [31:0] expCpsr;
    logic [31:0] expSpsr;
    fd = $fopen("verification/psr_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file verification/psr_trace.txt");
      errorCount++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                    fn, fw, alu, mask, exc, rst, cop, expCpsr, expSpsr);
        if (n == 9) begin
          stimQ.push_back({fn, fw, alu, mask, exc, rst, cop});
          expectQ.push_back({expCpsr, expSpsr});
        end else begin
          $display("A trace line could not be read: %0s", line);
          errorCount++;
        end
      end
    end
    $fclose(fd);
    if (stimQ.size() == 0) begin
      $display("The trace file holds no vectors");
      errorCount++;
    end
  endtask

  task automatic driveInputs(input logic [49:0] v, input logic run);
    {flagsNext, flagsWrite, aluOut, msrMask, exceptions, restoreCpsr, coprocFlagUpdate} = v;
    notStall = run; // Low holds every register
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      errorCount++;
    end
  endtask

  initial begin
    int gap;
    void'($urandom(32'h107));
    clk = 1'b0;
    reset = 1'b1;
    driveInputs('0, 1'b1); // Idle inputs
    errorCount = 0;
    loadTrace();
    traceLoaded = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < stimQ.size(); i++) begin
      if (i > 0) begin
        gap = $urandom % 3; // Stall cycles before this vector
        repeat (gap) begin
          driveInputs(stimQ[i], 1'b0);
          @(negedge clk);
          checkValue("cpsrData", expectQ[i-1][63:32], cpsrData); // Held
          checkValue("spsrData", expectQ[i-1][31:0], spsrData);
        end
      end
      driveInputs(stimQ[i], 1'b1);
      @(negedge clk);
      checkValue("cpsrData", expectQ[i][63:32], cpsrData);
      checkValue("spsrData", expectQ[i][31:0], spsrData);
    end
    $display("Checked %0d vectors, %0d errors", stimQ.size(), errorCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Worst case is three cycles per vector
  initial begin
    wait (traceLoaded);
    #((stimQ.size() + 4) * 4 * 4);
    $display("Timeout, the trace did not finish in time");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/psr_trace.txt
# flagsNext flagsWrite aluOut msrMask(R f s x c) exceptions(undef swi pabt dabt irq fiq)
# restoreCpsr coprocFlagUpdate, then expected cpsrData spsrData after the cycle
0 0 00000000 00 00 0 0 000002D3 00000000 # reset value, svc bank
A 1 00000000 00 00 0 0 A00002D3 00000000
0 0 00000013 01 00 0 0 A0000213 00000000 # clear I and F
5 0 00000000 00 3A 0 0 50000292 50000213 # irq wins, new flags
C 1 00000000 00 02 0 0 C0000292 50000213 # irq in irq ignored
3 0 00000000 00 09 0 0 300002D1 30000292 # fiq over pabt, F set
0 0 00000000 00 00 1 0 30000292 50000213 # restore to irq
9 0 00000000 00 25 0 0 90000297 90000292 # data abort wins
F 0 00000000 00 28 0 0 9000029B 90000297 # pabt skipped, undef old flags
6 0 00000000 00 10 0 0 90000293 9000029B # swi old flags
0 0 60000000 00 02 0 1 60000292 60000293 # coproc flags on entry
0 1 B0000000 00 00 0 1 B0000292 60000293
0 0 12345678 1A 00 0 0 B0000292 12005693 # SPSR f and x
0 0 000000C5 01 00 0 0 B00002D2 12005693 # illegal mode kept
0 0 40000010 09 00 0 0 40000210 40000210 # to user
0 0 8F1F3C13 0F 00 0 0 8F000210 8F000210 # user, flags byte only
0 0 50000000 18 00 0 0 8F000210 8F000210 # user has no SPSR
0 0 00000000 00 10 0 0 80000293 8F000210
0 0 00000000 00 00 1 0 8F000210 8F000210
2 1 00000000 00 01 0 0 200002D1 2F000210
0 0 0000001F 01 00 0 0 2000021F 2000021F # to system
E 0 00000000 00 05 0 0 E0000297 E000021F
0 0 70000000 08 20 0 0 E000029B E0000297 # exception beats MSR
0 0 30000000 08 00 1 0 3000029B E0000297 # MSR beats restore
0 0 A1B2C3D4 1C 00 1 0 3000029B A1B20297 # SPSR write beats restore
0 0 00000000 00 00 1 0 A1B20297 E000021F
5 1 00000000 00 00 0 0 51B20297 E000021F
0 0 000000FA 11 00 0 0 51B20297 E00002FF # SPSR illegal mode kept
